//--- sources.f
logic/soc_pkg.sv
logic/uart_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_port.sv
logic/data_ram.sv
logic/mem_bridge.sv
logic/lsu_bridge_top.sv
bench/tb_serial_model.sv
bench/tb_lsu_bridge.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_lsu_bridge -f sources.f -o Vtb_lsu_bridge
./obj_dir/Vtb_lsu_bridge

//--- bench/tb_lsu_bridge.sv
`default_nettype none

module tb_lsu_bridge;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS       = 8;
    localparam int BIT_NS       = uart_pkg::CLKS_PER_BIT * CLK_NS;
    localparam int RAM_STORES   = 64;  // partial stores after the fill
    localparam int BYTES_SENT   = 7;   // 3 tx, 1 rx, 2 overrun, 1 isolation
    localparam int RAM_ACCESSES = 2 * soc_pkg::RAM_DEPTH + RAM_STORES + 16;
    localparam int WATCHDOG_NS  = 2 * (BYTES_SENT * 12 * BIT_NS + RAM_ACCESSES * 2 * CLK_NS)
                                  + 200 * CLK_NS;

    logic              clk = 1'b0;
    logic              rst;
    logic              lsu_req;
    logic              lsu_we;
    soc_pkg::addr_t    lsu_addr;
    soc_pkg::byte_en_t lsu_be;
    soc_pkg::word_t    lsu_wdata;
    soc_pkg::word_t    lsu_rdata;
    logic              lsu_resp;
    wire               rxd;
    wire               txd;

    soc_pkg::word_t       ref_mem [soc_pkg::RAM_DEPTH]; // expected RAM contents
    uart_pkg::uart_byte_t tx_bytes [3];
    string                test_name = "reset";

    always #(CLK_NS / 2) clk = ~clk;

    lsu_bridge_top uut (
        .clk_i      (clk),
        .rst_i      (rst),
        .lsu_req_i  (lsu_req),
        .lsu_we_i   (lsu_we),
        .lsu_addr_i (lsu_addr),
        .lsu_be_i   (lsu_be),
        .lsu_wdata_i(lsu_wdata),
        .lsu_rdata_o(lsu_rdata),
        .lsu_resp_o (lsu_resp),
        .rxd_i      (rxd),
        .txd_o      (txd)
    );

    tb_serial_model model (
        .clk_i(clk),
        .txd_i(txd),
        .rxd_o(rxd)
    );

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("[FAIL] %s: %s expected %h actual %h", test, what, exp, act);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_error(input string msg);
        $display("error: %s", msg);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // response never comes without a request the cycle before
    a_resp_needs_req: assert property (@(posedge clk) disable iff (rst)
        lsu_resp |-> $past(lsu_req))
        else report_error("response pulse without a request");

    a_txd_idle_in_reset: assert property (@(posedge clk) rst |=> txd)
        else report_error("txd not high after a reset cycle");

    // one request, held until the response pulse is seen
    task automatic bus_access(input logic we, input soc_pkg::addr_t addr,
                              input soc_pkg::byte_en_t be, input soc_pkg::word_t wdata,
                              output soc_pkg::word_t rdata, output int lat);
        @(negedge clk); // idle cycle between requests
        lsu_req   = 1'b1;
        lsu_we    = we;
        lsu_addr  = addr;
        lsu_be    = be;
        lsu_wdata = wdata;
        lat       = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!lsu_resp);
        rdata   = lsu_rdata;
        lsu_req = 1'b0;
        lsu_we  = 1'b0;
    endtask

    // status word as the register map defines it
    function automatic soc_pkg::word_t stat_word(input logic tx_idle, input logic rx_avail);
        soc_pkg::word_t w;
        w = '0;
        w[soc_pkg::STAT_TX_IDLE_BIT]  = tx_idle;
        w[soc_pkg::STAT_RX_AVAIL_BIT] = rx_avail;
        return w;
    endfunction

    // bit 31 low keeps it off the serial regs, upper bits otherwise random
    function automatic soc_pkg::addr_t ram_addr(input soc_pkg::ram_index_t idx);
        return {1'b0, 21'($urandom), idx, 2'b00};
    endfunction

    task automatic load_expect(input soc_pkg::addr_t addr, input soc_pkg::word_t exp,
                               input string what);
        soc_pkg::word_t rdata;
        int             lat;
        bus_access(1'b0, addr, 4'hf, '0, rdata, lat);
        assert (lat == 1) else report_mismatch(test_name, {what, " latency"}, 1, lat);
        assert (rdata == exp) else report_mismatch(test_name, what, exp, rdata);
    endtask

    task automatic store_fixed(input soc_pkg::addr_t addr, input soc_pkg::byte_en_t be,
                               input soc_pkg::word_t wdata);
        soc_pkg::word_t rdata;
        int             lat;
        bus_access(1'b1, addr, be, wdata, rdata, lat);
        assert (lat == 1) else report_mismatch(test_name, "store latency", 1, lat);
    endtask

    // store plus per lane merge into the reference
    task automatic ram_write(input soc_pkg::ram_index_t idx, input soc_pkg::byte_en_t be,
                             input soc_pkg::word_t wdata);
        store_fixed(ram_addr(idx), be, wdata);
        for (int l = 0; l < 4; l++) begin
            if (be[l]) ref_mem[idx][8*l +: 8] = wdata[8*l +: 8];
        end
    endtask

    // poll status until a byte is waiting
    task automatic wait_rx_avail();
        soc_pkg::word_t stat;
        int             lat;
        do begin
            bus_access(1'b0, soc_pkg::UART_STAT_ADDR, 4'hf, '0, stat, lat);
            assert (lat == 1) else report_mismatch(test_name, "status latency", 1, lat);
        end while (!stat[soc_pkg::STAT_RX_AVAIL_BIT]);
        assert (stat == stat_word(1'b1, 1'b1))
            else report_mismatch(test_name, "status with byte", stat_word(1'b1, 1'b1), stat);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("error: watchdog expired after %0d ns, a response or frame never came",
                 WATCHDOG_NS);
        $display("TESTS FAILED");
        $fatal(1, "watchdog");
    end

    initial begin
        soc_pkg::word_t       rdata;
        uart_pkg::uart_byte_t rx_a;
        uart_pkg::uart_byte_t rx_b;
        int                   lat;
        void'($urandom(32'h51294e60));
        rst       = 1'b1;
        lsu_req   = 1'b0;
        lsu_we    = 1'b0;
        lsu_addr  = '0;
        lsu_be    = '0;
        lsu_wdata = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        @(negedge clk);
        assert (lsu_resp == 1'b0) else report_mismatch(test_name, "resp", 0, 32'(lsu_resp));
        assert (txd == 1'b1) else report_mismatch(test_name, "txd", 1, 32'(txd));
        load_expect(soc_pkg::UART_STAT_ADDR, stat_word(1'b1, 1'b0), "status");

        test_name = "ram";
        for (int i = 0; i < soc_pkg::RAM_DEPTH; i++) begin
            ram_write(soc_pkg::ram_index_t'(i), 4'hf, $urandom); // full fill, no X lanes
        end
        for (int i = 0; i < RAM_STORES; i++) begin
            ram_write(8'($urandom), 4'($urandom), $urandom);
        end
        for (int i = 0; i < soc_pkg::RAM_DEPTH; i++) begin
            load_expect(ram_addr(soc_pkg::ram_index_t'(i)), ref_mem[i], "ram word");
        end

        test_name = "uart_tx";
        for (int i = 0; i < 3; i++) begin
            tx_bytes[i] = 8'($urandom);
            if (i > 0) begin
                assert (model.in_frame)
                    else report_error("uart_tx: serial model idle, store not held off");
            end
            bus_access(1'b1, soc_pkg::UART_DATA_ADDR, 4'hf, {24'($urandom), tx_bytes[i]},
                       rdata, lat);
            if (i == 0) begin
                assert (lat == 1) else report_mismatch(test_name, "first store latency", 1, lat);
            end else begin
                assert (lat > 1) else report_mismatch(test_name, "held store latency", 2, lat);
            end
            // previous frame already decoded when the response comes
            assert (model.frame_q.size() == i)
                else report_mismatch(test_name, "frames done", i, model.frame_q.size());
        end
        while (model.frame_q.size() < 3) @(negedge clk);
        for (int i = 0; i < 3; i++) begin
            assert (model.frame_q[i] == tx_bytes[i])
                else report_mismatch(test_name, "frame byte", 32'(tx_bytes[i]),
                                     32'(model.frame_q[i]));
        end

        test_name = "uart_rx";
        rx_a = 8'($urandom);
        model.send_byte(rx_a);
        wait_rx_avail();
        load_expect(soc_pkg::UART_DATA_ADDR, 32'(rx_a), "rx byte");
        load_expect(soc_pkg::UART_STAT_ADDR, stat_word(1'b1, 1'b0), "status after pop");

        test_name = "uart_overrun";
        rx_a = 8'($urandom);
        rx_b = 8'($urandom);
        model.send_byte(rx_a);
        model.send_byte(rx_b); // overwrites the first
        wait_rx_avail();
        load_expect(soc_pkg::UART_DATA_ADDR, 32'(rx_b), "second rx byte");
        load_expect(soc_pkg::UART_STAT_ADDR, stat_word(1'b1, 1'b0), "status after pop");

        test_name = "isolation";
        ram_write(8'hfe, 4'hf, $urandom); // index of the data reg
        ram_write(8'hff, 4'hf, $urandom); // index of the status reg
        tx_bytes[0] = 8'($urandom);
        bus_access(1'b1, soc_pkg::UART_DATA_ADDR, 4'hf, {24'($urandom), tx_bytes[0]},
                   rdata, lat);
        store_fixed(soc_pkg::UART_STAT_ADDR, 4'hf, $urandom); // ignored
        load_expect(soc_pkg::UART_STAT_ADDR, stat_word(1'b0, 1'b0), "status, tx busy");
        load_expect(ram_addr(8'hfe), ref_mem[8'hfe], "aliased word fe");
        load_expect(ram_addr(8'hff), ref_mem[8'hff], "aliased word ff");
        while (model.frame_q.size() < 4) @(negedge clk);
        assert (model.frame_q[3] == tx_bytes[0])
            else report_mismatch(test_name, "frame byte", 32'(tx_bytes[0]),
                                 32'(model.frame_q[3]));

        if (model.stop_err_cnt == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("error: %0d frames on txd had a low stop bit", model.stop_err_cnt);
            $display("TESTS FAILED");
            $fatal(1, "bad stop bits");
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_serial_model.sv
`default_nettype none

module tb_serial_model (
    input  wire  clk_i,
    input  wire  txd_i,
    output logic rxd_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic                 rxd_q = 1'b1;   // line idles high
    logic                 in_frame = 1'b0; // txd frame in progress
    int                   stop_err_cnt = 0;
    uart_pkg::uart_byte_t frame_q [$];    // bytes decoded from txd, oldest first

    assign rxd_o = rxd_q;

    // one 8N1 frame on rxd, lsb first, bit edges on the falling clock
    task automatic send_byte(input uart_pkg::uart_byte_t data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0}; // stop, data, start
        @(negedge clk_i);
        for (int i = 0; i < 10; i++) begin
            rxd_q = frame[i];
            repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk_i);
        end
    endtask

    // frame decoder for txd
    initial begin
        uart_pkg::uart_byte_t data;
        forever begin
            @(negedge txd_i); // start edge
            in_frame = 1'b1;
            repeat (uart_pkg::CLKS_PER_BIT / 2) @(negedge clk_i); // middle of start bit
            for (int i = 0; i < 8; i++) begin
                repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk_i);
                data[i] = txd_i; // mid bit sample
            end
            repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk_i);
            if (!txd_i) stop_err_cnt++; // stop bit must be high
            frame_q.push_back(data);
            // rest of the stop bit, frame only counts as gone after it
            repeat (uart_pkg::CLKS_PER_BIT / 2) @(negedge clk_i);
            in_frame = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/lsu_bridge_top.sv
`default_nettype none

module lsu_bridge_top (
    input  wire               clk_i,
    input  wire               rst_i,
    input  wire               lsu_req_i,
    input  wire               lsu_we_i,
    input  soc_pkg::addr_t    lsu_addr_i,
    input  soc_pkg::byte_en_t lsu_be_i,
    input  soc_pkg::word_t    lsu_wdata_i,
    output soc_pkg::word_t    lsu_rdata_o,
    output logic              lsu_resp_o,
    input  wire               rxd_i,
    output logic              txd_o
);

    // bridge <-> ram
    logic                 ram_we;
    logic                 ram_re;
    soc_pkg::ram_index_t  ram_index;
    soc_pkg::byte_en_t    ram_be;
    soc_pkg::word_t       ram_wdata;
    soc_pkg::word_t       ram_rdata;

    // bridge <-> serial port
    logic                 rx_pop;
    logic                 tx_push;
    uart_pkg::uart_byte_t tx_byte;
    logic                 tx_idle;
    logic                 rx_avail;
    uart_pkg::uart_byte_t rx_byte;

    mem_bridge u_bridge (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .lsu_req_i  (lsu_req_i),
        .lsu_we_i   (lsu_we_i),
        .lsu_addr_i (lsu_addr_i),
        .lsu_be_i   (lsu_be_i),
        .lsu_wdata_i(lsu_wdata_i),
        .lsu_rdata_o(lsu_rdata_o),
        .lsu_resp_o (lsu_resp_o),
        .ram_we_o   (ram_we),
        .ram_re_o   (ram_re),
        .ram_index_o(ram_index),
        .ram_be_o   (ram_be),
        .ram_wdata_o(ram_wdata),
        .ram_rdata_i(ram_rdata),
        .rx_pop_o   (rx_pop),
        .tx_push_o  (tx_push),
        .tx_byte_o  (tx_byte),
        .tx_idle_i  (tx_idle),
        .rx_avail_i (rx_avail),
        .rx_byte_i  (rx_byte)
    );

    data_ram u_ram (
        .clk_i  (clk_i),
        .we_i   (ram_we),
        .re_i   (ram_re),
        .index_i(ram_index),
        .be_i   (ram_be),
        .wdata_i(ram_wdata),
        .rdata_o(ram_rdata)
    );

    uart_port u_uart (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rxd_i     (rxd_i),
        .txd_o     (txd_o),
        .rx_pop_i  (rx_pop),
        .tx_push_i (tx_push),
        .tx_byte_i (tx_byte),
        .tx_idle_o (tx_idle),
        .rx_avail_o(rx_avail),
        .rx_byte_o (rx_byte)
    );

endmodule

`default_nettype wire

//--- logic/mem_bridge.sv
`default_nettype none

module mem_bridge (
    input  wire                  clk_i,
    input  wire                  rst_i,
    // load/store port
    input  wire                  lsu_req_i,
    input  wire                  lsu_we_i,
    input  soc_pkg::addr_t       lsu_addr_i,
    input  soc_pkg::byte_en_t    lsu_be_i,
    input  soc_pkg::word_t       lsu_wdata_i,
    output soc_pkg::word_t       lsu_rdata_o,
    output logic                 lsu_resp_o,
    // data RAM side
    output logic                 ram_we_o,
    output logic                 ram_re_o,
    output soc_pkg::ram_index_t  ram_index_o,
    output soc_pkg::byte_en_t    ram_be_o,
    output soc_pkg::word_t       ram_wdata_o,
    input  soc_pkg::word_t       ram_rdata_i,
    // serial port side
    output logic                 rx_pop_o,
    output logic                 tx_push_o,
    output uart_pkg::uart_byte_t tx_byte_o,
    input  wire                  tx_idle_i,
    input  wire                  rx_avail_i,
    input  uart_pkg::uart_byte_t rx_byte_i
);

    logic           is_data;     // serial data reg hit
    logic           is_stat;     // status reg hit
    logic           is_ram;
    logic           tx_hold;     // data store waiting on tx
    logic           accept;
    logic           resp_q;
    logic           ram_sel_q;   // read mux select, set at accept
    soc_pkg::word_t stat_word;
    soc_pkg::word_t uart_rdata_q;

    // address decode, anything off the serial regs goes to RAM
    assign is_data = (lsu_addr_i == soc_pkg::UART_DATA_ADDR);
    assign is_stat = (lsu_addr_i == soc_pkg::UART_STAT_ADDR);
    assign is_ram  = ~is_data & ~is_stat;

    // only back-pressure in the design
    assign tx_hold = lsu_we_i & is_data & ~tx_idle_i;
    assign accept  = lsu_req_i & ~resp_q & ~tx_hold; // no accept in a resp cycle

    // strobes fire in the accept cycle
    assign ram_we_o    = accept & lsu_we_i & is_ram;
    assign ram_re_o    = accept & ~lsu_we_i & is_ram;
    assign ram_index_o = lsu_addr_i[soc_pkg::RAM_INDEX_W+1:2]; // skip byte offset
    assign ram_be_o    = lsu_be_i;
    assign ram_wdata_o = lsu_wdata_i;
    assign rx_pop_o    = accept & ~lsu_we_i & is_data; // every data load pops
    assign tx_push_o   = accept & lsu_we_i & is_data; // status stores just respond
    assign tx_byte_o   = lsu_wdata_i[7:0];

    always_comb begin
        stat_word = '0;
        stat_word[soc_pkg::STAT_TX_IDLE_BIT]  = tx_idle_i;
        stat_word[soc_pkg::STAT_RX_AVAIL_BIT] = rx_avail_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            resp_q    <= 1'b0;
            ram_sel_q <= 1'b0;
        end else begin
            resp_q <= accept; // one cycle after acceptance
            if (accept) ram_sel_q <= is_ram;
        end
    end

    // capture serial read value before the pop lands
    always_ff @(posedge clk_i) begin
        if (accept) uart_rdata_q <= is_stat ? stat_word : soc_pkg::word_t'(rx_byte_i);
    end

    assign lsu_rdata_o = ram_sel_q ? ram_rdata_i : uart_rdata_q;
    assign lsu_resp_o  = resp_q;

    a_resp_single: assert property (@(posedge clk_i) disable iff (rst_i)
        lsu_resp_o |=> !lsu_resp_o);

    a_push_when_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        tx_push_o |-> tx_idle_i);

endmodule

`default_nettype wire

//--- logic/data_ram.sv
`default_nettype none

module data_ram (
    input  wire                clk_i,
    input  wire                we_i,
    input  wire                re_i,
    input  soc_pkg::ram_index_t index_i,
    input  soc_pkg::byte_en_t  be_i,
    input  soc_pkg::word_t     wdata_i,
    output soc_pkg::word_t     rdata_o
);

    soc_pkg::word_t mem_q [soc_pkg::RAM_DEPTH]; // contents survive reset
    soc_pkg::word_t rdata_q;

    // per lane write
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int i = 0; i < $bits(soc_pkg::byte_en_t); i++) begin
                if (be_i[i]) mem_q[index_i][8*i +: 8] <= wdata_i[8*i +: 8];
            end
        end
    end

    // registered read, lines up with the response pulse
    always_ff @(posedge clk_i) begin
        if (re_i) rdata_q <= mem_q[index_i];
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- logic/uart_port.sv
`default_nettype none

module uart_port (
    input  wire                  clk_i,
    input  wire                  rst_i,
    input  wire                  rxd_i,
    output logic                 txd_o,
    input  wire                  rx_pop_i,
    input  wire                  tx_push_i,
    input  uart_pkg::uart_byte_t tx_byte_i,
    output logic                 tx_idle_o,
    output logic                 rx_avail_o,
    output uart_pkg::uart_byte_t rx_byte_o
);

    uart_pkg::uart_byte_t rx_data;   // straight from receiver
    logic                 rx_strobe;
    logic                 tx_busy;
    uart_pkg::uart_byte_t rx_buf_q;  // one byte receive buffer
    logic                 rx_avail_q;

    uart_rx u_rx (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .rxd_i   (rxd_i),
        .byte_o  (rx_data),
        .strobe_o(rx_strobe)
    );

    // push goes straight in as start, busy rises on the same edge
    uart_tx u_tx (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .start_i(tx_push_i),
        .byte_i (tx_byte_i),
        .txd_o  (txd_o),
        .busy_o (tx_busy)
    );

    // new byte overwrites, reception beats pop
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_avail_q <= 1'b0;
        end else if (rx_strobe) begin
            rx_avail_q <= 1'b1;
        end else if (rx_pop_i) begin
            rx_avail_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rx_strobe) rx_buf_q <= rx_data;
    end

    assign rx_byte_o  = rx_buf_q;
    assign rx_avail_o = rx_avail_q;
    assign tx_idle_o  = ~tx_busy;

    // bridge only pops a full buffer
    a_pop_needs_avail: assert property (@(posedge clk_i) disable iff (rst_i)
        rx_pop_i |-> rx_avail_o);

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
`default_nettype none

module uart_tx (
    input  wire                  clk_i,
    input  wire                  rst_i,
    input  wire                  start_i,
    input  uart_pkg::uart_byte_t byte_i,
    output logic                 txd_o,
    output logic                 busy_o
);

    uart_pkg::tx_state_t   state_q;
    uart_pkg::baud_count_t baud_q;
    uart_pkg::bit_count_t  bit_q;
    uart_pkg::uart_byte_t  shift_q;
    logic                  bit_end;

    assign bit_end = (baud_q == uart_pkg::baud_count_t'(uart_pkg::CLKS_PER_BIT - 1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= uart_pkg::TX_IDLE;
            baud_q  <= '0;
            bit_q   <= '0;
            txd_o   <= 1'b1; // line idles high
        end else begin
            baud_q <= bit_end ? '0 : baud_q + 1'b1;
            case (state_q)
                uart_pkg::TX_IDLE: begin
                    baud_q <= '0;
                    if (start_i) begin
                        txd_o   <= 1'b0; // start bit
                        state_q <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START: begin
                    if (bit_end) begin
                        txd_o   <= shift_q[0];
                        bit_q   <= '0;
                        state_q <= uart_pkg::TX_DATA;
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_end) begin
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == 3'd7) begin
                            txd_o   <= 1'b1; // stop bit
                            state_q <= uart_pkg::TX_STOP;
                        end else begin
                            txd_o <= shift_q[1]; // next bit, shift happens below
                        end
                    end
                end
                uart_pkg::TX_STOP: begin
                    if (bit_end) state_q <= uart_pkg::TX_IDLE;
                end
                default: state_q <= uart_pkg::TX_IDLE;
            endcase
        end
    end

    // frame payload, loaded on start and shifted at each data bit boundary
    always_ff @(posedge clk_i) begin
        if (state_q == uart_pkg::TX_IDLE && start_i) begin
            shift_q <= byte_i;
        end else if (state_q == uart_pkg::TX_DATA && bit_end) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    assign busy_o = (state_q != uart_pkg::TX_IDLE); // start + 8 data + stop

    a_no_start_when_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        start_i |-> !busy_o);

endmodule

`default_nettype wire

//--- logic/uart_rx.sv
`default_nettype none

module uart_rx (
    input  wire                 clk_i,
    input  wire                 rst_i,
    input  wire                 rxd_i,
    output uart_pkg::uart_byte_t byte_o,
    output logic                strobe_o
);

    logic                    rxd_s1_q;
    logic                    rxd_s2_q; // synchronized line
    uart_pkg::rx_state_t     state_q;
    uart_pkg::baud_count_t   baud_q;
    uart_pkg::bit_count_t    bit_q;
    uart_pkg::uart_byte_t    shift_q;

    // two flop synchronizer, line idles high
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rxd_s1_q <= 1'b1;
            rxd_s2_q <= 1'b1;
        end else begin
            rxd_s1_q <= rxd_i;
            rxd_s2_q <= rxd_s1_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q  <= uart_pkg::RX_IDLE;
            baud_q   <= '0;
            bit_q    <= '0;
            strobe_o <= 1'b0;
        end else begin
            strobe_o <= 1'b0; // single cycle pulse
            case (state_q)
                uart_pkg::RX_IDLE: begin
                    baud_q <= '0;
                    if (!rxd_s2_q) state_q <= uart_pkg::RX_START; // falling edge seen
                end
                uart_pkg::RX_START: begin
                    // recheck at mid start bit, glitches go back to idle
                    if (baud_q == uart_pkg::baud_count_t'(uart_pkg::CLKS_PER_BIT / 2 - 1)) begin
                        baud_q  <= '0;
                        bit_q   <= '0;
                        state_q <= rxd_s2_q ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end else begin
                        baud_q <= baud_q + 1'b1;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (baud_q == uart_pkg::baud_count_t'(uart_pkg::CLKS_PER_BIT - 1)) begin
                        baud_q <= '0;
                        bit_q  <= bit_q + 1'b1;
                        if (bit_q == 3'd7) state_q <= uart_pkg::RX_STOP; // last data bit
                    end else begin
                        baud_q <= baud_q + 1'b1;
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (baud_q == uart_pkg::baud_count_t'(uart_pkg::CLKS_PER_BIT - 1)) begin
                        strobe_o <= rxd_s2_q; // framing error, byte dropped
                        state_q  <= uart_pkg::RX_IDLE;
                    end else begin
                        baud_q <= baud_q + 1'b1;
                    end
                end
                default: state_q <= uart_pkg::RX_IDLE;
            endcase
        end
    end

    // lsb first, shift in from the top at mid bit
    always_ff @(posedge clk_i) begin
        if (state_q == uart_pkg::RX_DATA &&
            baud_q == uart_pkg::baud_count_t'(uart_pkg::CLKS_PER_BIT - 1)) begin
            shift_q <= {rxd_s2_q, shift_q[7:1]};
        end
    end

    assign byte_o = shift_q;

endmodule

`default_nettype wire

//--- logic/uart_pkg.sv
`default_nettype none

package uart_pkg;

    typedef logic [7:0] uart_byte_t;

    // clocks per serial bit, kept small for simulation
    localparam int CLKS_PER_BIT = 8;

    typedef logic [3:0] baud_count_t; // counts up to CLKS_PER_BIT
    typedef logic [2:0] bit_count_t;  // data bit 0..7

    // receiver fsm
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    // transmitter fsm
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

endpackage

`default_nettype wire

//--- logic/soc_pkg.sv
`default_nettype none

package soc_pkg;

    typedef logic [31:0] addr_t;    // byte address, load/store port
    typedef logic [31:0] word_t;    // data word
    typedef logic [3:0]  byte_en_t; // one enable per byte lane, active high

    // data RAM geometry
    localparam int RAM_INDEX_W = 8;
    localparam int RAM_DEPTH   = 256;

    // word index, taken from addr bits just above the byte offset
    typedef logic [RAM_INDEX_W-1:0] ram_index_t;

    // serial port registers
    localparam addr_t UART_DATA_ADDR = 32'hbfd003f8; // load pops rx, store sends low byte
    localparam addr_t UART_STAT_ADDR = 32'hbfd003fc; // read only

    // status register bits, everything else reads zero
    localparam int STAT_TX_IDLE_BIT  = 0;
    localparam int STAT_RX_AVAIL_BIT = 1;

endpackage

`default_nettype wire
